// File: hdl/memPkg.sv
`default_nettype none

package memPkg;

    // Datapath geometry
    localparam int dataWidth   = 32;               // One word
    localparam int laneCount   = dataWidth / 8;    // Byte lanes per word
    localparam int offsetWidth = $clog2(laneCount); // Byte offset inside a word

    // Memory geometry
    localparam int wordDepth  = 256;               // Words in the data RAM
    localparam int indexWidth = $clog2(wordDepth); // 8 bits of word index
    localparam int addrWidth  = 32;                // Byte address from the core

    // Access size, same codes as the load/store decoder
    typedef enum logic [1:0] {
        sizeWord = 2'b00,   // lw / sw
        sizeHalf = 2'b01,   // lh / sh
        sizeByte = 2'b10,   // lb / sb
        sizeNone = 2'b11    // Unused code, always rejected
    } accessSize_t;

    // Access as issued by the core, 68 bits
    typedef struct packed {
        logic [addrWidth-1:0] address;    // Byte address
        logic [dataWidth-1:0] writeData;  // Store data, right aligned
        accessSize_t          size;
        logic                 read;       // Level strobe
        logic                 write;      // Level strobe, wins over read
    } memReq_t;

    // Lane oriented request into the RAM
    typedef struct packed {
        logic [indexWidth-1:0]  index;    // Word index, wraps past wordDepth
        logic [laneCount-1:0]   byteEn;   // One bit per byte lane
        logic [dataWidth-1:0]   laneData; // Store data replicated onto lanes
        logic                   read;
        logic                   write;
        logic [offsetWidth-1:0] offset;   // Byte offset for the load side
        accessSize_t            size;
        logic                   fault;    // Misaligned or sizeNone
    } ramReq_t;

    // Response back to the core
    typedef struct packed {
        logic                 valid;      // One cycle pulse per read
        logic [dataWidth-1:0] readData;   // Sign extended load value
        logic                 fault;      // Rejected access, reads and writes
    } memRsp_t;

endpackage

`default_nettype wire

// File: hdl/storeAlign.sv
`default_nettype none

module storeAlign (
    input  memPkg::memReq_t memReq,
    output memPkg::ramReq_t ramReq
);
    import memPkg::*;

    logic [offsetWidth-1:0] offset;
    logic                   request;
    logic                   misaligned;
    logic                   writeOk;

    assign offset  = memReq.address[offsetWidth-1:0]; // Low address bits
    assign request = memReq.read | memReq.write;      // Any access this cycle

    // Alignment check per size
    always_comb begin
        case (memReq.size)
            sizeWord: misaligned = 1'b0;      // Word ignores the low bits
            sizeHalf: misaligned = offset[0]; // Offsets 1 and 3
            sizeByte: misaligned = 1'b0;      // Any byte is fine
            default:  misaligned = 1'b1;      // sizeNone
        endcase
    end

    // Only an aligned store may touch the array
    assign writeOk = memReq.write & ~misaligned;

    always_comb begin
        ramReq = '0;

        // Index comes from the bits above the offset, upper bits dropped
        ramReq.index  = memReq.address[offsetWidth +: indexWidth];
        ramReq.offset = offset;
        ramReq.size   = memReq.size;

        // Write wins over read when both strobes are up
        ramReq.read  = memReq.read & ~memReq.write;
        ramReq.write = writeOk;
        ramReq.fault = request & misaligned;

        // Lane data and enables
        case (memReq.size)
            sizeWord: begin
                ramReq.laneData = memReq.writeData;
                ramReq.byteEn   = 4'b1111;                // All lanes
            end
            sizeHalf: begin
                // Same halfword on both pairs, enables pick one
                ramReq.laneData = {2{memReq.writeData[15:0]}};
                ramReq.byteEn   = offset[1] ? 4'b1100 : 4'b0011;
            end
            sizeByte: begin
                ramReq.laneData = {4{memReq.writeData[7:0]}}; // Byte on every lane
                ramReq.byteEn   = 4'b0001 << offset;
            end
            default: begin
                ramReq.laneData = '0;
                ramReq.byteEn   = '0;
            end
        endcase

        // No enables for loads or rejected stores
        if (!writeOk) begin
            ramReq.byteEn = '0;
        end

        // A rejected read keeps its read marker, so the response side
        // still answers it with a zero word and the fault bit
    end

endmodule

`default_nettype wire

// File: hdl/dataRam.sv
`default_nettype none

module dataRam (
    input  logic                         Clock,
    input  logic                         rstN,
    input  memPkg::ramReq_t              ramReq,
    output logic [memPkg::dataWidth-1:0] ramWord,
    output memPkg::ramReq_t              laneInfo
);
    import memPkg::*;

    logic [dataWidth-1:0]   mem [wordDepth]; // Word array, not initialised
    logic                   doRead;
    logic                   rdFlag;          // Response due next cycle
    logic                   faultFlag;       // Registered reject
    logic [offsetWidth-1:0] offsetReg;
    accessSize_t            sizeReg;

    // Read only when no write is in the same cycle
    assign doRead = ramReq.read & ~ramReq.write;

    // Byte enabled write port
    always_ff @(posedge Clock) begin
        if (ramReq.write) begin
            for (int lane = 0; lane < laneCount; lane++) begin
                if (ramReq.byteEn[lane]) begin
                    mem[ramReq.index][lane*8 +: 8] <= ramReq.laneData[lane*8 +: 8];
                end
            end
        end
    end

    // Registered read port
    // Word and lane selection are captured together on a read
    always_ff @(posedge Clock) begin
        if (doRead) begin
            ramWord   <= mem[ramReq.index]; // Old contents if written this edge
            offsetReg <= ramReq.offset;
            sizeReg   <= ramReq.size;
        end
    end

    // Control flags
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            rdFlag    <= 1'b0;
            faultFlag <= 1'b0;
        end else begin
            rdFlag    <= doRead;       // One cycle pulse per read
            faultFlag <= ramReq.fault; // Reads and writes alike
        end
    end

    // Lane information for the load side
    always_comb begin
        laneInfo        = '0;         // Index, enables and data stay here
        laneInfo.offset = offsetReg;
        laneInfo.size   = sizeReg;
        laneInfo.read   = rdFlag;
        laneInfo.fault  = faultFlag;
    end

endmodule

`default_nettype wire

// File: hdl/loadExtract.sv
`default_nettype none

module loadExtract (
    input  logic [memPkg::dataWidth-1:0] ramWord,
    input  memPkg::ramReq_t              laneInfo,
    output memPkg::memRsp_t              memRsp
);
    import memPkg::*;

    logic [15:0]          halfLane;   // Selected halfword
    logic [7:0]           byteLane;   // Selected byte
    logic [dataWidth-1:0] extended;   // Lane after sign extension

    // Upper or lower halfword by offset bit 1
    assign halfLane = laneInfo.offset[1] ? ramWord[31:16] : ramWord[15:0];

    // Byte lane straight from the offset
    assign byteLane = ramWord[8*laneInfo.offset +: 8];

    // Sign extension per size
    always_comb begin
        case (laneInfo.size)
            sizeWord: begin
                extended = ramWord;                          // Unchanged
            end
            sizeHalf: begin
                extended = {{16{halfLane[15]}}, halfLane};  // From bit 15
            end
            sizeByte: begin
                extended = {{24{byteLane[7]}}, byteLane};   // From bit 7
            end
            default: begin
                extended = '0;                               // sizeNone, faulted anyway
            end
        endcase
    end

    // Response
    always_comb begin
        memRsp.valid = laneInfo.read;  // Rejected reads carry the read flag too
        memRsp.fault = laneInfo.fault;
        // Rejected load reads as zero
        if (laneInfo.fault) begin
            memRsp.readData = '0;
        end else begin
            memRsp.readData = extended;
        end
    end

endmodule

`default_nettype wire

// File: hdl/memStage.sv
`default_nettype none

module memStage (
    input  logic            Clock,
    input  logic            rstN,
    input  memPkg::memReq_t memReq,
    output memPkg::memRsp_t memRsp
);
    import memPkg::*;

    ramReq_t              ramReq;   // Aligned request, same cycle
    logic [dataWidth-1:0] ramWord;  // Registered read word
    ramReq_t              laneInfo; // Registered offset, size and flags

    // Producer, combinational
    storeAlign i_storeAlign (
        .memReq (memReq),
        .ramReq (ramReq)
    );

    // Buffer, one cycle of latency
    dataRam i_dataRam (
        .Clock    (Clock),
        .rstN     (rstN),
        .ramReq   (ramReq),
        .ramWord  (ramWord),
        .laneInfo (laneInfo)
    );

    // Consumer on registered inputs
    loadExtract i_loadExtract (
        .ramWord  (ramWord),
        .laneInfo (laneInfo),
        .memRsp   (memRsp)
    );

endmodule

`default_nettype wire

// File: test/memRefModel.svh
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// Shadow of the data RAM, one entry per byte address
logic [7:0] shadowMem [wordDepth*laneCount];

// Halfword at an odd offset or the unused size code
function automatic logic isRejected(input memReq_t req);
    return (req.size == sizeNone) || ((req.size == sizeHalf) && req.address[0]);
endfunction

// Shadow position of byte 0 of the addressed word
function automatic int wordBase(input memReq_t req);
    return int'(req.address[2 +: indexWidth]) * laneCount; // Upper address bits wrap
endfunction

// Expected response one cycle after the request
function automatic memRsp_t expectRsp(input memReq_t req);
    memRsp_t     rsp;
    int          base;
    int          lane;
    logic [15:0] half;
    rsp  = '0;
    base = wordBase(req);
    lane = req.address[1:0];
    if (req.write) begin
        rsp.fault = isRejected(req);              // Stores never answer with data
    end else if (req.read) begin
        rsp.valid = 1'b1;
        rsp.fault = isRejected(req);              // Rejected load reads as zero
        if (!rsp.fault) begin
            case (req.size)
                sizeWord: begin
                    rsp.readData = {shadowMem[base+3], shadowMem[base+2],
                                    shadowMem[base+1], shadowMem[base]};
                end
                sizeHalf: begin
                    half         = {shadowMem[base+lane+1], shadowMem[base+lane]};
                    rsp.readData = {{16{half[15]}}, half};
                end
                default: begin
                    rsp.readData = {{24{shadowMem[base+lane][7]}}, shadowMem[base+lane]};
                end
            endcase
        end
    end
    return rsp;
endfunction

// Store into the shadow, only the addressed lanes
task automatic applyStore(input memReq_t req);
    int base;
    int lane;
    base = wordBase(req);
    lane = req.address[1:0];
    if (req.write && !isRejected(req)) begin
        case (req.size)
            sizeWord: begin
                for (int i = 0; i < laneCount; i++) begin
                    shadowMem[base+i] = req.writeData[8*i +: 8];
                end
            end
            sizeHalf: begin
                shadowMem[base+lane]   = req.writeData[7:0];
                shadowMem[base+lane+1] = req.writeData[15:8];
            end
            default: begin
                shadowMem[base+lane] = req.writeData[7:0]; // Single byte
            end
        endcase
    end
endtask

`endif

// File: test/memStageTb.sv
`default_nettype none

module memStageTb;
    timeunit 1ns;
    timeprecision 1ps;

    import memPkg::*;

    `include "memRefModel.svh"

    logic    Clock = 1'b0;
    logic    rstN;
    memReq_t memReq;
    memRsp_t memRsp;

    memRsp_t expQ[$];          // Expected responses, oldest first
    int      tagQ[$];          // Cycle at which each one was driven
    int      cycleCount = 0;
    int      checkCount = 0;
    int      validErrors = 0;
    int      faultErrors = 0;
    int      dataErrors = 0;
    int      idleErrors = 0;

    memStage i_dut (
        .Clock  (Clock),
        .rstN   (rstN),
        .memReq (memReq),
        .memRsp (memRsp)
    );

    always #4 Clock = ~Clock;  // 8 ns period

    // Cycle count and run limit
    // 256 fills, 256 reads, 3000 random ops and a few directed ones fit well below 4000
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= 4000) begin
            $display("Timeout after %0d cycles with %0d responses outstanding",
                     cycleCount, expQ.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic memReq_t buildReq(input logic [31:0] address, input logic [31:0] data,
                                         input accessSize_t size, input logic rd,
                                         input logic wr);
        memReq_t req;
        req.address   = address;
        req.writeData = data;
        req.size      = size;
        req.read      = rd;
        req.write     = wr;
        return req;
    endfunction

    // Drive on the falling edge and queue what should come back
    task automatic driveReq(input memReq_t req);
        @(negedge Clock);
        memReq = req;
        expQ.push_back(expectRsp(req));
        tagQ.push_back(cycleCount);
        applyStore(req);   // After the expectation, write wins over read anyway
    endtask

    task automatic checkRsp(input memRsp_t got, input memRsp_t exp);
        checkCount++;
        if (got.valid !== exp.valid) begin
            validErrors++;
            $display("Fail memRsp.valid got %h expected %h at cycle %0d",
                     got.valid, exp.valid, cycleCount);
        end
        if (got.fault !== exp.fault) begin
            faultErrors++;
            $display("Fail memRsp.fault got %h expected %h at cycle %0d",
                     got.fault, exp.fault, cycleCount);
        end
        if (got.readData !== exp.readData) begin
            dataErrors++;
            $display("Fail memRsp.readData got %h expected %h at cycle %0d",
                     got.readData, exp.readData, cycleCount);
        end
    endtask

    // No response due, both flags must be low
    task automatic checkIdle(input memRsp_t got);
        checkCount++;
        if (got.valid !== 1'b0 || got.fault !== 1'b0) begin
            idleErrors++;
            $display("Fail idle memRsp.valid %h memRsp.fault %h expected 0 at cycle %0d",
                     got.valid, got.fault, cycleCount);
        end
    endtask

    // Compare on the falling edge where the registered response is stable
    always @(negedge Clock) begin
        memRsp_t exp;
        if (expQ.size() > 0 && tagQ[0] < cycleCount) begin  // Sampled by a rising edge already
            exp = expQ.pop_front();
            void'(tagQ.pop_front());
            if (exp.valid || exp.fault) begin
                checkRsp(memRsp, exp);
            end else begin
                checkIdle(memRsp);
            end
        end else begin
            checkIdle(memRsp);       // Reset and start up
        end
    end

    initial begin
        int          pick;
        int          errorTotal;
        logic [31:0] addr;
        logic [31:0] lastAddr;
        accessSize_t size;
        void'($urandom(71));
        // Faulting read held during reset, flags must stay low anyway
        memReq   = buildReq(32'h1, 32'h0, sizeHalf, 1'b1, 1'b0);
        rstN     = 1'b0;
        lastAddr = '0;
        repeat (2) @(posedge Clock);
        @(negedge Clock);
        memReq = '0;
        rstN   = 1'b1;
        repeat (3) driveReq(buildReq(32'h0, 32'h0, sizeWord, 1'b0, 1'b0)); // Quiet after reset

        // Word round trip over the whole array
        for (int i = 0; i < wordDepth; i++) begin
            driveReq(buildReq(i * 4, $urandom, sizeWord, 1'b0, 1'b1));
        end
        for (int i = 0; i < wordDepth; i++) begin
            driveReq(buildReq(i * 4, 32'h0, sizeWord, 1'b1, 1'b0));
        end

        // Partial stores keep the other lanes
        driveReq(buildReq(5 * 4 + 2, 32'h0000_8123, sizeHalf, 1'b0, 1'b1));
        driveReq(buildReq(5 * 4, 32'h0, sizeWord, 1'b1, 1'b0));
        driveReq(buildReq(6 * 4 + 1, 32'h0000_007f, sizeByte, 1'b0, 1'b1));
        driveReq(buildReq(6 * 4 + 3, 32'h0000_0080, sizeByte, 1'b0, 1'b1));
        driveReq(buildReq(6 * 4, 32'h0, sizeWord, 1'b1, 1'b0));

        // Sign extension with top bits set and clear
        driveReq(buildReq(7 * 4, 32'h8001_7f80, sizeWord, 1'b0, 1'b1));
        for (int off = 0; off < 4; off++) begin
            driveReq(buildReq(7 * 4 + off, 32'h0, sizeByte, 1'b1, 1'b0));
        end
        driveReq(buildReq(7 * 4, 32'h0, sizeHalf, 1'b1, 1'b0));
        driveReq(buildReq(7 * 4 + 2, 32'h0, sizeHalf, 1'b1, 1'b0));

        // Rejected accesses
        driveReq(buildReq(8 * 4 + 1, 32'h0, sizeHalf, 1'b1, 1'b0));
        driveReq(buildReq(8 * 4 + 3, 32'h0, sizeHalf, 1'b1, 1'b0));
        driveReq(buildReq(8 * 4, 32'h0, sizeNone, 1'b1, 1'b0));
        driveReq(buildReq(8 * 4 + 1, 32'h0000_dead, sizeHalf, 1'b0, 1'b1));
        driveReq(buildReq(8 * 4 + 3, 32'h0000_beef, sizeHalf, 1'b1, 1'b1));  // Both strobes
        driveReq(buildReq(8 * 4, 32'hffff_ffff, sizeNone, 1'b0, 1'b1));
        driveReq(buildReq(8 * 4, 32'h0, sizeWord, 1'b1, 1'b0));              // Word unchanged

        // Random back to back traffic
        for (int n = 0; n < 3000; n++) begin
            pick = $urandom_range(9, 0);
            if ($urandom_range(3, 0) == 0) begin
                addr      = lastAddr;                    // Same word as the previous op
                addr[1:0] = $urandom_range(3, 0);
            end else begin
                addr = $urandom;
            end
            size = accessSize_t'($urandom_range(3, 0));
            driveReq(buildReq(addr, $urandom, size,
                              (pick < 4) || (pick == 8),        // Read 40 percent
                              ((pick >= 4) && (pick < 8)) || (pick == 8)));
            lastAddr = addr;
        end

        // Drain
        repeat (2) driveReq(buildReq(32'h0, 32'h0, sizeWord, 1'b0, 1'b0));
        while (expQ.size() != 0) begin
            @(posedge Clock);
        end

        errorTotal = validErrors + faultErrors + dataErrors + idleErrors;
        $display("Checks %0d errors valid %0d fault %0d readData %0d idle %0d total %0d",
                 checkCount, validErrors, faultErrors, dataErrors, idleErrors, errorTotal);
        if (errorTotal == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+test
hdl/memPkg.sv
hdl/storeAlign.sv
hdl/dataRam.sv
hdl/loadExtract.sv
hdl/memStage.sv
test/memStageTb.sv
